// ==== files.f ====
+incdir+include
src/spi_cmd_pkg.sv
src/cart_pkg.sv
src/spi_cmd_if.sv
src/spi_slave.sv
src/sysclk_meter.sv
src/mcu_cmd.sv
src/cart_ctrl_top.sv
verification/cart_ctrl_asserts.sv
verification/tb_cart_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cartridge control testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal -f files.f --top-module tb_cart_ctrl -o sim_cart_ctrl &&
./obj_dir/sim_cart_ctrl &&
echo "simulation finished" ||
{ echo "simulation returned an error status"; exit 1; }

// ==== verification/cart_ctrl_testdata.txt ====
# count(hex) bytes replies, then mapper rom_mask saveram_mask mem_addr dac_play featurebits
# -- is don't care, rr is an LFSR byte, mm is the byte expected from the memory model
3 F0 00 00  -- A5 A5  1 000000 000000 000000 0 00
2 35 00  -- 35  5 000000 000000 000000 0 00
4 10 12 34 56  -- 10 10 10  5 123456 000000 000000 0 00
4 20 00 1F FF  -- 20 20 20  5 123456 001FFF 000000 0 00
2 ED 5C  -- ED  5 123456 001FFF 000000 0 5C
4 FF 11 22 33  -- 5C 11 22  5 -- -- -- 0 5C
2 E2 00  -- E2  5 -- -- -- 1 --
4 00 00 00 40  -- 00 00 00  -- -- -- 000040 1 --
7 98 rr rr rr rr rr rr  -- 98 98 98 98 98 98  -- -- -- 000046 1 --
4 00 00 00 80  -- 00 00 00  -- -- -- 000080 -- --
4 90 rr rr rr  -- 90 90 90  -- -- -- 000080 -- --
4 00 00 00 3E  -- 00 00 00  -- -- -- 00003E -- --
B 88 00 00 00 00 00 00 00 00 00 00  -- mm mm mm mm mm mm mm mm mm mm  -- -- -- 000049 -- --
3 80 00 00  -- mm mm  -- -- -- 000049 -- --
2 E1 00  -- E1  -- -- -- -- 0 --
5 FE 00 00 00 00  -- -- -- -- --  -- -- -- -- -- --

// ==== verification/tb_cart_ctrl.sv ====
`include "cart_cfg.svh"

module tb_cart_ctrl import cart_pkg::*;;

  localparam int EXP_FREQ = `CART_METER_WINDOW * 20 / 60;

  logic       clk;
  logic       rst;
  logic       spi_sck;
  logic       spi_ss;
  logic       spi_mosi;
  logic       spi_miso;
  logic       snes_sysclk;
  mapper_t    mapper;
  cart_mask_t rom_mask;
  cart_mask_t saveram_mask;
  cart_addr_t mem_addr;
  logic       mem_rd;
  logic       mem_wr;
  logic [7:0] mem_wdata;
  logic [7:0] mem_rdata;
  logic       dac_play;
  logic [7:0] featurebits;

  // transfers from the data file
  int          num_xfers;
  int          total_bytes;
  int          xfer_len [32];
  logic [7:0]  xfer_byte [32][16];
  logic        xfer_rand [32][16];
  logic [7:0]  rep_val [32][16];
  int          rep_mode [32][16];
  logic [31:0] port_val [32][6];
  logic        port_care [32][6];

  logic [7:0]  mem [256];
  logic [7:0]  exp_mem [256];
  logic [23:0] exp_addr;
  logic [7:0]  tx_buf [16];
  logic [7:0]  rx_buf [16];
  logic [31:0] lfsr;
  int          cycles;
  int          cycle_limit;
  int          rd_pulses;

  cart_ctrl_top dut (.*);

  always #10 clk = ~clk;
  always #30 snes_sysclk = ~snes_sysclk;

  // memory model with combinational read
  assign mem_rdata = mem[mem_addr[7:0]];
  always @(posedge clk) begin
    if (mem_wr)
      mem[mem_addr[7:0]] <= mem_wdata;
  end

  // read strobes seen on the memory bus
  always @(posedge clk) begin
    if (mem_rd)
      rd_pulses <= rd_pulses + 1;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Testbench failed");
      $fatal(1, "timeout");
    end
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("Testbench failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  // galois LFSR stepped once per bit taken
  task automatic next_rand_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++) begin
      b = {b[6:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
    end
  endtask

  function automatic logic [31:0] hex_token(input string s);
    logic [31:0] v;
    v = '0;
    void'($sscanf(s, "%h", v));
    return v;
  endfunction

  task automatic load_testdata();
    int    fd;
    int    n;
    string tok;
    string rest;
    fd = $fopen("verification/cart_ctrl_testdata.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the test data file");
      $display("Testbench failed");
      $fatal(1, "missing data file");
    end
    while (!$feof(fd)) begin
      if ($fscanf(fd, "%s", tok) != 1)
        break;
      if (tok[0] == "#") begin
        void'($fgets(rest, fd));
        continue;
      end
      n = int'(hex_token(tok));
      xfer_len[num_xfers] = n;
      total_bytes += n;
      for (int i = 0; i < n; i++) begin
        void'($fscanf(fd, "%s", tok));
        xfer_rand[num_xfers][i] = (tok == "rr");
        xfer_byte[num_xfers][i] = 8'(hex_token(tok));
      end
      for (int i = 0; i < n; i++) begin
        void'($fscanf(fd, "%s", tok));
        rep_mode[num_xfers][i] = (tok == "--") ? 0 : (tok == "mm") ? 2 : 1;
        rep_val[num_xfers][i] = 8'(hex_token(tok));
      end
      for (int j = 0; j < 6; j++) begin
        void'($fscanf(fd, "%s", tok));
        port_care[num_xfers][j] = (tok != "--");
        port_val[num_xfers][j] = hex_token(tok);
      end
      num_xfers++;
    end
    $fclose(fd);
  endtask

  // SPI mode 0 master with a half period of 4 clk cycles
  task automatic spi_xfer(input int n);
    spi_ss = 1'b0;
    wait_cycles(4);
    for (int i = 0; i < n; i++) begin
      for (int b = 7; b >= 0; b--) begin
        spi_sck  = 1'b0;
        spi_mosi = tx_buf[i][b];
        wait_cycles(4);
        rx_buf[i][b] = spi_miso;
        spi_sck = 1'b1;
        wait_cycles(4);
      end
    end
    spi_sck = 1'b0;
    wait_cycles(4);
    spi_ss = 1'b1;
    // strobe, read data and address step settle within a few cycles
    wait_cycles(8);
  endtask

  task automatic run_transfer(input int t);
    int          n;
    int          rd_start;
    logic        inc;
    logic [31:0] f;
    logic [31:0] got;
    string       pname;
    n = xfer_len[t];
    for (int i = 0; i < n; i++) begin
      if (xfer_rand[t][i])
        next_rand_byte(tx_buf[i]);
      else
        tx_buf[i] = xfer_byte[t][i];
    end
    inc = tx_buf[0][3];
    rd_start = rd_pulses;
    spi_xfer(n);
    // one read strobe per completed byte of a memory read
    check_value("mem_rd pulses", 32'(rd_pulses - rd_start),
                (tx_buf[0][7:4] == 4'h8) ? 32'(n) : 32'd0);
    for (int i = 1; i < n; i++) begin
      if (rep_mode[t][i] == 1)
        check_value("reply", rx_buf[i], rep_val[t][i]);
      else if (rep_mode[t][i] == 2)
        check_value("read reply", rx_buf[i], exp_mem[8'(exp_addr + (inc ? i - 1 : 0))]);
    end
    if (tx_buf[0] == 8'hFE) begin
      f = {rx_buf[1], rx_buf[2], rx_buf[3], rx_buf[4]};
      // window edges may add or drop one sysclk edge
      if (f + 1 >= EXP_FREQ && f <= EXP_FREQ + 1)
        f = EXP_FREQ;
      check_value("freq", f, EXP_FREQ);
    end
    // expected address and memory contents
    if (tx_buf[0][7:4] == 4'h0 && n == 4)
      exp_addr = {tx_buf[1], tx_buf[2], tx_buf[3]};
    if (tx_buf[0][7:4] == 4'h9) begin
      for (int i = 1; i < n; i++) begin
        exp_mem[exp_addr[7:0]] = tx_buf[i];
        if (inc)
          exp_addr++;
      end
    end
    if (tx_buf[0][7:4] == 4'h8 && inc)
      exp_addr += 24'(n);
    for (int j = 0; j < 6; j++) begin
      case (j)
        0: begin
          pname = "mapper";
          got   = 32'(mapper);
        end
        1: begin
          pname = "rom_mask";
          got   = 32'(rom_mask);
        end
        2: begin
          pname = "saveram_mask";
          got   = 32'(saveram_mask);
        end
        3: begin
          pname = "mem_addr";
          got   = 32'(mem_addr);
        end
        4: begin
          pname = "dac_play";
          got   = 32'(dac_play);
        end
        default: begin
          pname = "featurebits";
          got   = 32'(featurebits);
        end
      endcase
      if (port_care[t][j])
        check_value(pname, got, port_val[t][j]);
    end
  endtask

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    spi_sck     = 1'b0;
    spi_ss      = 1'b1;
    spi_mosi    = 1'b0;
    snes_sysclk = 1'b0;
    cycles      = 0;
    rd_pulses   = 0;
    cycle_limit = 1_000_000;
    num_xfers   = 0;
    total_bytes = 0;
    exp_addr    = '0;
    lfsr        = 32'hada3_28f7;
    for (int i = 0; i < 256; i++) begin
      mem[i]     = 8'(i) ^ 8'h5A;
      exp_mem[i] = 8'(i) ^ 8'h5A;
    end
    load_testdata();
    cycle_limit = total_bytes * 80 + 200;
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    wait_cycles(1);
    check_value("mapper", 32'(mapper), 1);
    check_value("dac_play", 32'(dac_play), 0);
    check_value("mem_rd", 32'(mem_rd), 0);
    check_value("mem_wr", 32'(mem_wr), 0);
    check_value("mem_addr", 32'(mem_addr), 0);
    check_value("spi_miso", 32'(spi_miso), 0);
    for (int t = 0; t < num_xfers; t++)
      run_transfer(t);
    // memory model against the writes the transfers should have made
    for (int i = 0; i < 256; i++)
      check_value($sformatf("mem[%0d]", i), 32'(mem[i]), 32'(exp_mem[i]));
    $display("Testbench passed");
    $finish;
  end

endmodule

// ==== verification/cart_ctrl_asserts.sv ====
module cart_ctrl_asserts (
  input logic       clk,
  input logic       rst,
  input logic       mem_rd,
  input logic       mem_wr,
  input logic       cmd_ready,
  input logic       param_ready,
  input logic [7:0] cmd_data
);

  a_strobe_excl: assert property (@(posedge clk) disable iff (rst) !(mem_rd && mem_wr))
    else $error("mem_rd and mem_wr are high in the same cycle");

  // writes only come from the memory write group
  a_wr_group: assert property (@(posedge clk) disable iff (rst) mem_wr |-> cmd_data[7:4] == 4'h9)
    else $error("mem_wr is high outside the memory write group");

  a_rd_pulse: assert property (@(posedge clk) disable iff (rst) mem_rd |=> !mem_rd)
    else $error("mem_rd lasts longer than one cycle");

  a_wr_pulse: assert property (@(posedge clk) disable iff (rst) mem_wr |=> !mem_wr)
    else $error("mem_wr lasts longer than one cycle");

  a_ready_excl: assert property (@(posedge clk) disable iff (rst) !(cmd_ready && param_ready))
    else $error("cmd_ready and param_ready are high in the same cycle");

endmodule

bind mcu_cmd cart_ctrl_asserts u_asserts (
  .clk         (clk),
  .rst         (rst),
  .mem_rd      (mem_rd),
  .mem_wr      (mem_wr),
  .cmd_ready   (bus.cmd_ready),
  .param_ready (bus.param_ready),
  .cmd_data    (bus.cmd_data)
);

// ==== src/cart_ctrl_top.sv ====
module cart_ctrl_top import cart_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       spi_sck,
  input  logic       spi_ss,
  input  logic       spi_mosi,
  output logic       spi_miso,
  input  logic       snes_sysclk,
  output mapper_t    mapper,
  output cart_mask_t rom_mask,
  output cart_mask_t saveram_mask,
  output cart_addr_t mem_addr,
  output logic       mem_rd,
  output logic       mem_wr,
  output logic [7:0] mem_wdata,
  input  logic [7:0] mem_rdata,
  output logic       dac_play,
  output logic [7:0] featurebits
);

  freq_t freq;

  spi_cmd_if spi_bus ();

  // SPI pins to byte strobes
  spi_slave u_spi (
    .clk  (clk),
    .rst  (rst),
    .sck  (spi_sck),
    .ss   (spi_ss),
    .mosi (spi_mosi),
    .miso (spi_miso),
    .bus  (spi_bus.front)
  );

  sysclk_meter u_meter (
    .clk    (clk),
    .rst    (rst),
    .sysclk (snes_sysclk),
    .freq   (freq)
  );

  mcu_cmd u_cmd (
    .bus          (spi_bus.decoder),
    .clk          (clk),
    .rst          (rst),
    .freq         (freq),
    .mem_rdata    (mem_rdata),
    .mapper       (mapper),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask),
    .mem_addr     (mem_addr),
    .mem_rd       (mem_rd),
    .mem_wr       (mem_wr),
    .mem_wdata    (mem_wdata),
    .dac_play     (dac_play),
    .featurebits  (featurebits)
  );

endmodule

// ==== src/mcu_cmd.sv ====
`include "cart_cfg.svh"

module mcu_cmd import cart_pkg::*, spi_cmd_pkg::*; (
  spi_cmd_if.decoder bus,
  input  logic       clk,
  input  logic       rst,
  input  freq_t      freq,
  input  logic [7:0] mem_rdata,
  output mapper_t    mapper,
  output cart_mask_t rom_mask,
  output cart_mask_t saveram_mask,
  output cart_addr_t mem_addr,
  output logic       mem_rd,
  output logic       mem_wr,
  output logic [7:0] mem_wdata,
  output logic       dac_play,
  output logic [7:0] featurebits
);

  cmd_byte_u  cmd;
  logic       byte_done;
  logic       sel_d1;
  logic       sel_d2;
  logic       read_take;
  logic       addr_step;
  freq_t      freq_snap;
  logic [7:0] freq_byte;

  assign cmd       = bus.cmd_data;
  assign byte_done = bus.cmd_ready | bus.param_ready;

  // parameter bytes 1..3 fill a 24 bit value MSB first
  function automatic cart_addr_t load_lane(
    input cart_addr_t cur,
    input logic [7:0] idx,
    input logic [7:0] data,
    input logic       clear_low
  );
    cart_addr_t nxt;
    nxt = cur;
    case (idx)
      8'd2: begin
        nxt[`CART_ADDR_W-1 -: 8] = data;
        if (clear_low)
          nxt[`CART_ADDR_W-9:0] = '0;
      end
      8'd3: nxt[15:8] = data;
      8'd4: nxt[7:0] = data;
      default: ;
    endcase
    return nxt;
  endfunction

  // read strobe one cycle after each byte, data taken two cycles later
  assign mem_rd    = sel_d1 && (cmd.grp.group_id == GRP_MEM_RD);
  assign read_take = sel_d2 && (cmd.grp.group_id == GRP_MEM_RD);
  assign addr_step = cmd.grp.arg[3] && (mem_wr || read_take);

  ////////////////////////////////////////////////////////////////////////////
  // configuration registers and memory strobes
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      mapper       <= mapper_t'(1);
      rom_mask     <= '0;
      saveram_mask <= '0;
      mem_addr     <= '0;
      mem_wr       <= 1'b0;
      dac_play     <= 1'b0;
      featurebits  <= '0;
      sel_d1       <= 1'b0;
      sel_d2       <= 1'b0;
    end else begin
      sel_d1 <= byte_done;
      sel_d2 <= sel_d1;
      mem_wr <= 1'b0;

      if (bus.cmd_ready) begin
        if (cmd.grp.group_id == GRP_MAPPER)
          mapper <= cmd.grp.arg;
        if (cmd.op == OP_DAC_PLAY)
          dac_play <= 1'b1;
        else if (cmd.op == OP_DAC_PAUSE)
          dac_play <= 1'b0;
      end

      if (bus.param_ready) begin
        case (cmd.grp.group_id)
          GRP_ADDR:
            mem_addr <= load_lane(mem_addr, bus.byte_cnt, bus.param_data, 1'b1);
          GRP_ROM_MASK:
            rom_mask <= load_lane(rom_mask, bus.byte_cnt, bus.param_data, 1'b0);
          GRP_SRAM_MASK:
            saveram_mask <= load_lane(saveram_mask, bus.byte_cnt, bus.param_data, 1'b0);
          GRP_MEM_WR:
            mem_wr <= 1'b1;
          default: ;
        endcase
        if (cmd.op == OP_FEATURE)
          featurebits <= bus.param_data;
      end

      // advance after the write strobe, or once read data is taken
      if (addr_step)
        mem_addr <= mem_addr + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // reply selection
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (bus.byte_cnt)
      8'd1:    freq_byte = freq_snap[31:24];
      8'd2:    freq_byte = freq_snap[23:16];
      8'd3:    freq_byte = freq_snap[15:8];
      8'd4:    freq_byte = freq_snap[7:0];
      default: freq_byte = 8'h00;
    endcase
  end

  always_ff @(posedge clk) begin
    if (bus.param_ready && cmd.grp.group_id == GRP_MEM_WR)
      mem_wdata <= bus.param_data;
    // snapshot once, so the four bytes belong to one window
    if (bus.cmd_ready && bus.byte_cnt == 8'd1 && cmd.op == OP_FREQ)
      freq_snap <= freq;
    if (sel_d2) begin
      case (cmd.op)
        OP_SIG:  bus.reply <= `CART_SIGNATURE;
        OP_FREQ: bus.reply <= freq_byte;
        OP_ECHO: bus.reply <= bus.param_data;
        default: bus.reply <= read_take ? mem_rdata : bus.cmd_data;
      endcase
    end
  end

endmodule

// ==== src/sysclk_meter.sv ====
`include "cart_cfg.svh"

module sysclk_meter import cart_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  sysclk,
  output freq_t freq
);

  logic [2:0] sys_sr;
  logic       sys_rise;
  freq_t      edge_cnt;
  logic [$clog2(`CART_METER_WINDOW)-1:0] win_cnt;
  logic       win_end;

  assign sys_rise = sys_sr[1] & ~sys_sr[2];
  assign win_end  = (win_cnt == $bits(win_cnt)'(`CART_METER_WINDOW - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      sys_sr   <= '0;
      edge_cnt <= '0;
      win_cnt  <= '0;
      freq     <= '0;
    end else begin
      sys_sr <= {sys_sr[1:0], sysclk};
      if (win_end) begin
        win_cnt  <= '0;
        // last cycle of the window still counts
        freq     <= edge_cnt + freq_t'(sys_rise);
        edge_cnt <= '0;
      end else begin
        win_cnt  <= win_cnt + 1'b1;
        edge_cnt <= edge_cnt + freq_t'(sys_rise);
      end
    end
  end

endmodule

// ==== src/spi_slave.sv ====
module spi_slave (
  input  logic clk,
  input  logic rst,
  input  logic sck,
  input  logic ss,
  input  logic mosi,
  output logic miso,
  spi_cmd_if.front bus
);

  logic [2:0] sck_sr;
  logic [1:0] ss_sr;
  logic [1:0] mosi_sr;
  logic [6:0] rx_sr;
  logic [7:0] tx_sr;
  logic       sck_rise;
  logic       sck_fall;
  logic       ss_idle;
  logic       rx_bit;

  ////////////////////////////////////////////////////////////////////////////
  // pin synchronizers and sck edge detect
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      sck_sr  <= '0;
      ss_sr   <= 2'b11;
      mosi_sr <= '0;
    end else begin
      sck_sr  <= {sck_sr[1:0], sck};
      ss_sr   <= {ss_sr[0], ss};
      mosi_sr <= {mosi_sr[0], mosi};
    end
  end

  assign sck_rise = sck_sr[1] & ~sck_sr[2];
  assign sck_fall = ~sck_sr[1] & sck_sr[2];
  assign ss_idle  = ss_sr[1];
  // mosi has the same sync depth as sck, so it lines up with the edge
  assign rx_bit   = mosi_sr[1];

  ////////////////////////////////////////////////////////////////////////////
  // bit / byte counters and byte strobes
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      bus.bit_cnt     <= '0;
      bus.byte_cnt    <= '0;
      bus.cmd_ready   <= 1'b0;
      bus.param_ready <= 1'b0;
      tx_sr           <= '0;
    end else begin
      bus.cmd_ready   <= 1'b0;
      bus.param_ready <= 1'b0;
      if (ss_idle) begin
        bus.bit_cnt  <= '0;
        bus.byte_cnt <= '0;
        tx_sr        <= '0;
      end else begin
        if (sck_rise) begin
          bus.bit_cnt <= bus.bit_cnt + 3'd1;
          if (bus.bit_cnt == 3'd7) begin
            if (bus.byte_cnt == 8'd0)
              bus.cmd_ready <= 1'b1;
            else
              bus.param_ready <= 1'b1;
            // saturate so a long transfer never looks like a new command
            if (bus.byte_cnt != 8'hFF)
              bus.byte_cnt <= bus.byte_cnt + 8'd1;
          end
        end
        // trailing fall of a byte loads the reply, the others shift
        if (sck_fall) begin
          if (bus.bit_cnt == 3'd0)
            tx_sr <= bus.reply;
          else
            tx_sr <= {tx_sr[6:0], 1'b0};
        end
      end
    end
  end

  // receive shifter
  always_ff @(posedge clk) begin
    if (sck_rise && !ss_idle) begin
      rx_sr <= {rx_sr[5:0], rx_bit};
      if (bus.bit_cnt == 3'd7) begin
        if (bus.byte_cnt == 8'd0)
          bus.cmd_data <= {rx_sr, rx_bit};
        else
          bus.param_data <= {rx_sr, rx_bit};
      end
    end
  end

  assign miso = ss ? 1'b0 : tx_sr[7];

endmodule

// ==== src/spi_cmd_if.sv ====
interface spi_cmd_if;

  logic       cmd_ready;
  logic       param_ready;
  logic [7:0] cmd_data;
  logic [7:0] param_data;
  logic [7:0] byte_cnt;
  logic [2:0] bit_cnt;
  // next byte to shift out on miso
  logic [7:0] reply;

  modport front (
    output cmd_ready, param_ready, cmd_data, param_data, byte_cnt, bit_cnt,
    input  reply
  );

  modport decoder (
    input  cmd_ready, param_ready, cmd_data, param_data, byte_cnt, bit_cnt,
    output reply
  );

endinterface

// ==== src/cart_pkg.sv ====
`include "cart_cfg.svh"

package cart_pkg;

  // cartridge memory address and the ROM / save-RAM masks
  typedef logic [`CART_ADDR_W-1:0] cart_addr_t;
  typedef logic [`CART_ADDR_W-1:0] cart_mask_t;

  // mapper number
  typedef logic [`CART_MAPPER_W-1:0] mapper_t;

  // sysclk edges per meter window
  typedef logic [`CART_FREQ_W-1:0] freq_t;

endpackage

// ==== src/spi_cmd_pkg.sv ====
package spi_cmd_pkg;

  // opcodes that use the whole command byte
  typedef enum logic [7:0] {
    OP_DAC_PAUSE = 8'hE1,
    OP_DAC_PLAY  = 8'hE2,
    OP_FEATURE   = 8'hED,
    OP_SIG       = 8'hF0,
    OP_FREQ      = 8'hFE,
    OP_ECHO      = 8'hFF
  } cmd_opcode_e;

  // group commands use the upper nibble and take the lower nibble as argument
  typedef enum logic [3:0] {
    GRP_ADDR      = 4'h0,
    GRP_ROM_MASK  = 4'h1,
    GRP_SRAM_MASK = 4'h2,
    GRP_MAPPER    = 4'h3,
    GRP_MEM_RD    = 4'h8,
    GRP_MEM_WR    = 4'h9
  } cmd_group_e;

  typedef struct packed {
    cmd_group_e  group_id;
    logic [3:0]  arg;      // bit 3 is auto-increment for memory groups
  } cmd_group_t;

  typedef union packed {
    cmd_opcode_e op;
    cmd_group_t  grp;
  } cmd_byte_u;

endpackage

// ==== include/cart_cfg.svh ====
`ifndef CART_CFG_SVH
`define CART_CFG_SVH

// cartridge memory address and mask width
`define CART_ADDR_W 24
`define CART_MAPPER_W 4

// reply byte for the signature command
`define CART_SIGNATURE 8'hA5

// window length of the sysclk meter in clk cycles
`define CART_METER_WINDOW 1024
`define CART_FREQ_W 32

`endif
